// ==== source/slm_pkg.sv ====
// frame geometry is fixed here; widths must stay consistent with frame_width/height/count
`default_nettype none

package slm_pkg;

    // ====================
    // frame geometry
    // ====================

    // pixels per line
    localparam int frame_width = 8;
    // lines per frame
    localparam int frame_height = 8;
    // frames held in memory
    localparam int frame_count = 4;
    localparam int mem_depth = frame_count * frame_height * frame_width;

    // accepted read to rd_valid, in cycles
    localparam int read_latency = 2;

    // ====================
    // field widths
    // ====================

    localparam int frame_bits = 2;
    localparam int line_bits = 3;
    localparam int col_bits = 3;
    localparam int pixel_bits = 8;
    localparam int offset_bits = 8;
    // signed room for position +/- offset
    localparam int coord_width = 10;

    // ====================
    // types
    // ====================

    typedef logic [pixel_bits-1:0] pixel_t;
    // frame, line, column from high to low
    typedef logic [frame_bits+line_bits+col_bits-1:0] addr_t;
    typedef logic [frame_bits-1:0] frame_id_t;
    typedef logic [line_bits-1:0] line_id_t;
    typedef logic [col_bits-1:0] col_id_t;
    // magnitude only, sign travels on its own wire
    typedef logic [offset_bits-1:0] offset_t;

    // sent for source positions outside the frame
    localparam pixel_t blank_pixel = '0;

endpackage

`default_nettype wire

// ==== source/offset_registers.sv ====
// sw[7:0] is the magnitude and sw[9] the sign (0 = right/down); sw[8] is not used
`timescale 1ns/1ps
`default_nettype none

module offset_registers (
    input  wire               CLOCK_50,
    input  wire               delayed_reset,
    input  wire               update_x,
    input  wire               update_y,
    input  wire [9:0]         sw,
    output slm_pkg::offset_t  offset_h,
    output logic              offset_h_sign,
    output slm_pkg::offset_t  offset_v,
    output logic              offset_v_sign
);

    // both pairs load independently, same key cycle allowed
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            // no shift after reset
            offset_h      <= '0;
            offset_h_sign <= 1'b0;
            offset_v      <= '0;
            offset_v_sign <= 1'b0;
        end else begin
            // horizontal pair
            if (update_x) begin
                offset_h      <= sw[7:0];
                offset_h_sign <= sw[9];
            end
            // vertical pair
            if (update_y) begin
                offset_v      <= sw[7:0];
                offset_v_sign <= sw[9];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pattern_writer.sv ====
// one fill writes all mem_depth words in order; a trigger while busy is ignored
`timescale 1ns/1ps
`default_nettype none

module pattern_writer (
    input  wire              CLOCK_50,
    input  wire              delayed_reset,
    input  wire              trigger,
    output logic             fill_start,
    output logic             wr_strobe,
    output slm_pkg::addr_t   wr_addr,
    output slm_pkg::pixel_t  wr_data,
    output logic             fill_done,
    output logic             fill_busy
);

    // ====================
    // fill state
    // ====================

    logic           busy;
    slm_pkg::addr_t addr_count;
    logic           last_word;

    // trigger only counts when idle
    assign fill_start = trigger && !busy;

    // final address of the array
    assign last_word = (addr_count == slm_pkg::addr_t'(slm_pkg::mem_depth - 1));

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            busy       <= 1'b0;
            addr_count <= '0;
        end else if (fill_start) begin
            // first write lands next cycle at address 0
            busy       <= 1'b1;
            addr_count <= '0;
        end else if (busy) begin
            addr_count <= addr_count + 1'b1;
            if (last_word) begin
                busy <= 1'b0;
            end
        end
    end

    // ====================
    // write port
    // ====================

    // one write per busy cycle
    assign wr_strobe = busy;
    assign wr_addr   = addr_count;
    // pattern is the address itself, so frame/line/col read back from the pixel
    assign wr_data   = slm_pkg::pixel_t'(addr_count);

    // same cycle as the last write
    assign fill_done = busy && last_word;
    assign fill_busy = busy;

endmodule

`default_nettype wire

// ==== source/line_loader.sv ====
// first pixel comes 3 cycles after the grant edge; grants during issue are ignored, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module line_loader (
    input  wire                 CLOCK_50,
    input  wire                 delayed_reset,
    input  wire                 load_grant,
    input  slm_pkg::line_id_t   line_id,
    input  slm_pkg::frame_id_t  frame_id,
    input  slm_pkg::offset_t    offset_h,
    input  wire                 offset_h_sign,
    input  slm_pkg::offset_t    offset_v,
    input  wire                 offset_v_sign,
    input  wire                 rd_valid,
    input  slm_pkg::pixel_t     rd_data,
    output logic                rd_req,
    output slm_pkg::addr_t      rd_addr,
    output logic                pixel_strobe,
    output slm_pkg::pixel_t     pixel,
    output logic                line_done
);

    // ====================
    // issue stage
    // ====================

    logic               issuing;
    slm_pkg::col_id_t   col;
    logic               last_col;
    logic               accept;

    // request snapshot taken at the grant
    slm_pkg::frame_id_t frame_q;
    slm_pkg::line_id_t  line_q;
    slm_pkg::offset_t   off_h_q;
    slm_pkg::offset_t   off_v_q;
    logic               sign_h_q;
    logic               sign_v_q;

    // source position, signed so out-of-frame shows up as negative or too large
    logic signed [slm_pkg::coord_width-1:0] src_col;
    logic signed [slm_pkg::coord_width-1:0] src_line;
    logic                                   in_range;

    assign accept   = load_grant && !issuing;
    assign last_col = (col == slm_pkg::col_id_t'(slm_pkg::frame_width - 1));

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            issuing <= 1'b0;
            col     <= '0;
        end else if (issuing) begin
            // column counter wraps back to 0 after the last slot
            col <= col + 1'b1;
            if (last_col) begin
                issuing <= 1'b0;
            end
        end else if (accept) begin
            issuing <= 1'b1;
            col     <= '0;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            frame_q  <= frame_id;
            line_q   <= line_id;
            off_h_q  <= offset_h;
            off_v_q  <= offset_v;
            sign_h_q <= offset_h_sign;
            sign_v_q <= offset_v_sign;
        end
    end

    // sign 0 moves the picture right/down, so the source sits before the output
    assign src_col  = sign_h_q ? $signed({1'b0, col}) + $signed({1'b0, off_h_q})
                               : $signed({1'b0, col}) - $signed({1'b0, off_h_q});
    assign src_line = sign_v_q ? $signed({1'b0, line_q}) + $signed({1'b0, off_v_q})
                               : $signed({1'b0, line_q}) - $signed({1'b0, off_v_q});

    assign in_range = (src_col >= 0) && (src_col < slm_pkg::frame_width)
                   && (src_line >= 0) && (src_line < slm_pkg::frame_height);

    // blank slots never touch the bus
    assign rd_req  = issuing && in_range;
    assign rd_addr = {frame_q, src_line[slm_pkg::line_bits-1:0], src_col[slm_pkg::col_bits-1:0]};

    // ====================
    // token pipeline
    // ====================

    // one token per slot, lined up with the memory read latency
    logic [slm_pkg::read_latency-1:0] tok_valid;
    logic [slm_pkg::read_latency-1:0] tok_blank;
    logic [slm_pkg::read_latency-1:0] tok_last;
    logic                             tok_out;

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            tok_valid <= '0;
            tok_blank <= '0;
            tok_last  <= '0;
        end else begin
            tok_valid <= {tok_valid[slm_pkg::read_latency-2:0], issuing};
            tok_blank <= {tok_blank[slm_pkg::read_latency-2:0], !in_range};
            tok_last  <= {tok_last[slm_pkg::read_latency-2:0], last_col};
        end
    end

    // a read lost to the writer returns no rd_valid and so no pixel
    assign tok_out = tok_valid[slm_pkg::read_latency-1]
                  && (tok_blank[slm_pkg::read_latency-1] || rd_valid);

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            pixel_strobe <= 1'b0;
            line_done    <= 1'b0;
        end else begin
            pixel_strobe <= tok_out;
            line_done    <= tok_out && tok_last[slm_pkg::read_latency-1];
        end
    end

    // merge blanks with memory data
    always_ff @(posedge CLOCK_50) begin
        pixel <= tok_blank[slm_pkg::read_latency-1] ? slm_pkg::blank_pixel : rd_data;
    end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
// writer owns the bus from fill_start through fill_done; loader reads during a fill are dropped
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire              CLOCK_50,
    input  wire              delayed_reset,
    input  wire              fill_start,
    input  wire              fill_done,
    input  wire              wr_strobe,
    input  slm_pkg::addr_t   wr_addr,
    input  slm_pkg::pixel_t  wr_data,
    input  wire              line_load,
    input  wire              rd_req,
    input  slm_pkg::addr_t   rd_addr,
    output logic             load_grant,
    output logic             mem_strobe,
    output logic             mem_write,
    output slm_pkg::addr_t   mem_addr,
    output slm_pkg::pixel_t  mem_wdata
);

    // ====================
    // ownership
    // ====================

    logic writer_owns;
    logic filled_once;

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            writer_owns <= 1'b0;
            filled_once <= 1'b0;
        end else if (fill_start) begin
            writer_owns <= 1'b1;
        end else if (fill_done) begin
            // bus returns to the loader after the last write
            writer_owns <= 1'b0;
            filled_once <= 1'b1;
        end
    end

    // fill_start cycle counts as running, its writes begin next cycle
    assign load_grant = line_load && filled_once && !writer_owns && !fill_start;

    // ====================
    // port mux
    // ====================

    assign mem_strobe = writer_owns ? wr_strobe : rd_req;
    // loader only ever reads
    assign mem_write  = writer_owns;
    assign mem_addr   = writer_owns ? wr_addr : rd_addr;
    assign mem_wdata  = wr_data;

endmodule

`default_nettype wire

// ==== source/frame_memory.sv ====
// single port, no wait state; read data returns read_latency (2) cycles after the strobe
`timescale 1ns/1ps
`default_nettype none

module frame_memory (
    input  wire              CLOCK_50,
    input  wire              delayed_reset,
    input  wire              mem_strobe,
    input  wire              mem_write,
    input  slm_pkg::addr_t   mem_addr,
    input  slm_pkg::pixel_t  mem_wdata,
    output logic             rd_valid,
    output slm_pkg::pixel_t  rd_data
);

    slm_pkg::pixel_t mem [slm_pkg::mem_depth];
    slm_pkg::addr_t  addr_q;
    logic            rd_pend;

    // ====================
    // address stage
    // ====================

    always_ff @(posedge CLOCK_50) begin
        if (mem_strobe && mem_write) begin
            mem[mem_addr] <= mem_wdata;
        end
        // registered read address
        addr_q <= mem_addr;
        // registered output
        rd_data <= mem[addr_q];
    end

    // read flag follows the address through both stages
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_pend  <= mem_strobe && !mem_write;
            rd_valid <= rd_pend;
        end
    end

endmodule

`default_nettype wire

// ==== source/slm_top.sv ====
// all inputs are clean single-cycle strobes on CLOCK_50; loads are dropped until a fill completes
`timescale 1ns/1ps
`default_nettype none

module slm_top (
    input  wire                 CLOCK_50,
    input  wire                 delayed_reset,
    input  wire                 trigger,
    input  wire                 update_x,
    input  wire                 update_y,
    input  wire [9:0]           sw,
    input  slm_pkg::frame_id_t  frame_id,
    input  wire                 line_load,
    input  slm_pkg::line_id_t   line_id,
    output logic                pixel_strobe,
    output slm_pkg::pixel_t     pixel,
    output logic                line_done,
    output logic                fill_busy
);

    // ====================
    // nets
    // ====================

    // offsets
    slm_pkg::offset_t offset_h;
    slm_pkg::offset_t offset_v;
    logic             offset_h_sign;
    logic             offset_v_sign;

    // writer side
    logic             fill_start;
    logic             fill_done;
    logic             wr_strobe;
    slm_pkg::addr_t   wr_addr;
    slm_pkg::pixel_t  wr_data;

    // loader side
    logic             load_grant;
    logic             rd_req;
    slm_pkg::addr_t   rd_addr;

    // memory port
    logic             mem_strobe;
    logic             mem_write;
    slm_pkg::addr_t   mem_addr;
    slm_pkg::pixel_t  mem_wdata;
    logic             rd_valid;
    slm_pkg::pixel_t  rd_data;

    // ====================
    // instances
    // ====================

    offset_registers offset_registers_inst (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .update_x      (update_x),
        .update_y      (update_y),
        .sw            (sw),
        .offset_h      (offset_h),
        .offset_h_sign (offset_h_sign),
        .offset_v      (offset_v),
        .offset_v_sign (offset_v_sign)
    );

    pattern_writer pattern_writer_inst (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .trigger       (trigger),
        .fill_start    (fill_start),
        .wr_strobe     (wr_strobe),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .fill_done     (fill_done),
        .fill_busy     (fill_busy)
    );

    line_loader line_loader_inst (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .load_grant    (load_grant),
        .line_id       (line_id),
        .frame_id      (frame_id),
        .offset_h      (offset_h),
        .offset_h_sign (offset_h_sign),
        .offset_v      (offset_v),
        .offset_v_sign (offset_v_sign),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .pixel_strobe  (pixel_strobe),
        .pixel         (pixel),
        .line_done     (line_done)
    );

    bus_arbiter bus_arbiter_inst (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .fill_start    (fill_start),
        .fill_done     (fill_done),
        .wr_strobe     (wr_strobe),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .line_load     (line_load),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .load_grant    (load_grant),
        .mem_strobe    (mem_strobe),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    frame_memory frame_memory_inst (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .mem_strobe    (mem_strobe),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// ==== verification/tb_slm_checks.svh ====
// included inside tb_slm_top; needs its errors/checks counters declared before the include
`ifndef tb_slm_checks_svh
`define tb_slm_checks_svh

// ====================
// compare tasks
// ====================

task automatic check_pixel(input string name, input slm_pkg::pixel_t got,
                           input slm_pkg::pixel_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
    end
endtask

// failures that have no value to compare
task automatic note_failure(input string what);
    errors++;
    $display("[ERROR] %0t %s", $time, what);
endtask

// ====================
// pixel model
// ====================

// sign 0 shifts right/down, so the source sits before the output position
function automatic slm_pkg::pixel_t expected_pixel(input int frame, input int line,
        input int col, input int off_h, input logic sign_h, input int off_v, input logic sign_v);
    int src_col;
    int src_line;
    src_col  = sign_h ? col + off_h : col - off_h;
    src_line = sign_v ? line + off_v : line - off_v;
    if (src_col < 0 || src_col >= slm_pkg::frame_width) begin
        return slm_pkg::blank_pixel;
    end
    if (src_line < 0 || src_line >= slm_pkg::frame_height) begin
        return slm_pkg::blank_pixel;
    end
    // stored word equals its packed address frame/line/column
    return slm_pkg::pixel_t'((frame * slm_pkg::frame_height + src_line)
                             * slm_pkg::frame_width + src_col);
endfunction

`endif

// ==== verification/tb_slm_top.sv ====
// table-driven test of slm_top; one entry at a time, no overlap between loads
`timescale 1ns/1ps
`default_nettype none

module tb_slm_top;

    typedef enum logic [1:0] {op_fill, op_load, op_offset} op_t;
    // alt: fill waits for the end, offset targets the vertical pair
    typedef struct packed {
        op_t                op;
        logic               alt;
        slm_pkg::frame_id_t frame;
        slm_pkg::line_id_t  line;
        logic [9:0]         sw;
        logic [3:0]         count;
    } entry_t;

    localparam int num_entries = 25;
    // budget of 300 cycles per table entry
    localparam int watchdog_cycles = num_entries * 300;

    logic CLOCK_50, delayed_reset, trigger, update_x, update_y, line_load;
    logic [9:0] sw;
    slm_pkg::frame_id_t frame_id;
    slm_pkg::line_id_t  line_id;
    logic pixel_strobe, line_done, fill_busy;
    slm_pkg::pixel_t pixel;

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int first_cycle = -1;
    int done_index = -1;
    slm_pkg::pixel_t pixels[$];
    // offsets as the testbench last set them
    int   model_off_h = 0;
    int   model_off_v = 0;
    logic model_sign_h = 1'b0;
    logic model_sign_v = 1'b0;

    `include "tb_slm_checks.svh"

    entry_t tbl [num_entries] = '{
        '{op_load,   1'b0, 2'd0, 3'd0, 10'h000, 4'd0},  // before any fill
        '{op_fill,   1'b1, 2'd0, 3'd0, 10'h000, 4'd0},
        '{op_load,   1'b0, 2'd0, 3'd0, 10'h000, 4'd8},
        '{op_offset, 1'b0, 2'd0, 3'd0, 10'h003, 4'd0},  // right 3
        '{op_load,   1'b0, 2'd1, 3'd2, 10'h000, 4'd8},
        '{op_offset, 1'b0, 2'd0, 3'd0, 10'h202, 4'd0},  // left 2
        '{op_load,   1'b0, 2'd2, 3'd5, 10'h000, 4'd8},
        '{op_offset, 1'b0, 2'd0, 3'd0, 10'h07f, 4'd0},
        '{op_load,   1'b0, 2'd3, 3'd7, 10'h000, 4'd8},
        '{op_offset, 1'b0, 2'd0, 3'd0, 10'h000, 4'd0},
        '{op_offset, 1'b1, 2'd0, 3'd0, 10'h002, 4'd0},  // down 2
        '{op_load,   1'b0, 2'd0, 3'd1, 10'h000, 4'd8},
        '{op_load,   1'b0, 2'd0, 3'd4, 10'h000, 4'd8},
        '{op_offset, 1'b1, 2'd0, 3'd0, 10'h201, 4'd0},  // up 1
        '{op_load,   1'b0, 2'd1, 3'd7, 10'h000, 4'd8},
        '{op_load,   1'b0, 2'd1, 3'd3, 10'h000, 4'd8},
        '{op_offset, 1'b1, 2'd0, 3'd0, 10'h000, 4'd0},
        '{op_load,   1'b0, 2'd1, 3'd6, 10'h000, 4'd8},
        '{op_load,   1'b0, 2'd2, 3'd1, 10'h000, 4'd8},
        '{op_load,   1'b0, 2'd3, 3'd3, 10'h000, 4'd8},
        '{op_offset, 1'b0, 2'd0, 3'd0, 10'h003, 4'd0},  // right 3 so a leaked grant shows blanks
        '{op_fill,   1'b0, 2'd0, 3'd0, 10'h000, 4'd0},  // second fill left running
        '{op_load,   1'b0, 2'd0, 3'd0, 10'h000, 4'd0},  // dropped during fill
        '{op_fill,   1'b1, 2'd0, 3'd0, 10'h000, 4'd0},  // trigger ignored, wait end
        '{op_load,   1'b0, 2'd2, 3'd4, 10'h000, 4'd8}
    };

    slm_top slm_top_inst (
        .CLOCK_50(CLOCK_50), .delayed_reset(delayed_reset), .trigger(trigger),
        .update_x(update_x), .update_y(update_y), .sw(sw), .frame_id(frame_id),
        .line_load(line_load), .line_id(line_id), .pixel_strobe(pixel_strobe),
        .pixel(pixel), .line_done(line_done), .fill_busy(fill_busy)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) cycle <= cycle + 1;

    // ====================
    // pixel collector
    // ====================

    // sampled on the falling edge, away from the DUT updates
    always @(negedge CLOCK_50) begin
        if (pixel_strobe === 1'b1) begin
            if (first_cycle < 0) begin
                first_cycle = cycle;
            end
            pixels.push_back(pixel);
        end
        if (line_done === 1'b1) begin
            check_flag("pixel_strobe", pixel_strobe, 1'b1);
            done_index = pixels.size();
        end
    end

    task automatic start_fill(input logic wait_end);
        int waited;
        @(posedge CLOCK_50);
        trigger <= 1'b1;
        @(posedge CLOCK_50);
        trigger <= 1'b0;
        @(negedge CLOCK_50);
        check_flag("fill_busy", fill_busy, 1'b1);
        if (wait_end) begin
            waited = 0;
            while (fill_busy !== 1'b0 && waited < 300) begin
                @(negedge CLOCK_50);
                waited++;
            end
            if (fill_busy !== 1'b0) begin
                note_failure("fill_busy stayed high for more than 300 cycles");
            end
        end
    endtask

    task automatic set_offset(input logic vertical, input logic [9:0] value);
        @(posedge CLOCK_50);
        sw <= value;
        if (vertical) begin
            update_y <= 1'b1;
            model_off_v  = int'(value[7:0]);
            model_sign_v = value[9];
        end else begin
            update_x <= 1'b1;
            model_off_h  = int'(value[7:0]);
            model_sign_h = value[9];
        end
        @(posedge CLOCK_50);
        update_x <= 1'b0;
        update_y <= 1'b0;
    endtask

    task automatic request_line(input slm_pkg::frame_id_t f, input slm_pkg::line_id_t l,
                                input int exp_count);
        int start_cycle;
        int waited;
        @(posedge CLOCK_50);
        pixels.delete();
        first_cycle = -1;
        done_index  = -1;
        frame_id  <= f;
        line_id   <= l;
        line_load <= 1'b1;
        start_cycle = cycle;
        @(posedge CLOCK_50);
        line_load <= 1'b0;
        if (exp_count == 0) begin
            // nothing may come back in this window
            repeat (20) @(posedge CLOCK_50);
        end else begin
            waited = 0;
            while (done_index < 0 && waited < 20) begin
                @(posedge CLOCK_50);
                waited++;
            end
            if (done_index < 0) begin
                note_failure("line_done did not arrive within 20 cycles of the load");
            end
            // catch any stray strobes after the line
            repeat (4) @(posedge CLOCK_50);
        end
        check_count("pixel_count", pixels.size(), exp_count);
        if (exp_count > 0) begin
            check_count("first_pixel_latency", first_cycle - start_cycle - 1, 4);
            check_count("line_done_position", done_index, exp_count);
            for (int i = 0; i < pixels.size() && i < exp_count; i++) begin
                check_pixel($sformatf("pixel[%0d]", i), pixels[i],
                            expected_pixel(int'(f), int'(l), i, model_off_h, model_sign_h,
                                           model_off_v, model_sign_v));
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        int errors_before;
        delayed_reset <= 1'b1;
        trigger   <= 1'b0;
        update_x  <= 1'b0;
        update_y  <= 1'b0;
        sw        <= '0;
        frame_id  <= '0;
        line_id   <= '0;
        line_load <= 1'b0;
        repeat (4) @(posedge CLOCK_50);
        delayed_reset <= 1'b0;
        for (int i = 0; i < num_entries; i++) begin
            errors_before = errors;
            case (tbl[i].op)
                op_fill:   start_fill(tbl[i].alt);
                op_offset: set_offset(tbl[i].alt, tbl[i].sw);
                default:   request_line(tbl[i].frame, tbl[i].line, int'(tbl[i].count));
            endcase
            $display("entry %0d %s frame %0d line %0d sw %h: %s", i, tbl[i].op.name(),
                     tbl[i].frame, tbl[i].line, tbl[i].sw,
                     (errors == errors_before) ? "ok" : "mismatch");
        end
        $display("entries %0d, checks %0d, errors %0d", num_entries, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        $display("%0t watchdog expired before the stimulus table completed", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verification
source/slm_pkg.sv
source/offset_registers.sv
source/pattern_writer.sv
source/line_loader.sv
source/bus_arbiter.sv
source/frame_memory.sv
source/slm_top.sv
verification/tb_slm_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the slm_top testbench with Verilator.
# Pass or fail is decided from the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -Wno-fatal --top-module tb_slm_top -f tb.f \
    --Mdir obj_dir -o tb_slm_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_slm_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see $log"
    exit 1
fi
